// ==== Bender.yml ====
package:
  name: mp4

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv32i_types.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/mp4control.sv
      - verilog/mp4datapath.sv
      - verilog/bmem_arbiter.sv
      - verilog/mp4.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_mp4.sv

// ==== compile.f ====
+incdir+verilog
+incdir+tb
verilog/rv32i_types.sv
verilog/regfile.sv
verilog/alu.sv
verilog/mp4control.sv
verilog/mp4datapath.sv
verilog/bmem_arbiter.sv
verilog/mp4.sv
tb/tb_mp4.sv

// ==== tb/rv32i_ref_model.svh ====
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// runs img from address 0 until the halt and queues one record per instruction
task automatic run_model();
    logic [31:0] xr [32];
    logic [31:0] pc, nxt, inst, a, b, res, addr, imm_i, imm_s, imm_b;
    logic [2:0] f3;
    logic wr, halted;
    commit_t c;
    for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
    end
    exp_q.delete();
    pc = 32'd0;
    halted = 1'b0;
    while (!halted) begin
        inst  = img[pc[10:2]];
        f3    = inst[14:12];
        a     = xr[inst[19:15]];
        b     = xr[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        c = '0;
        c.pc = pc;
        c.inst = inst;
        nxt = pc + 32'd4;
        wr = 1'b1;
        res = '0;
        case (inst[6:0])
            rv32i_types::op_lui: res = {inst[31:12], 12'd0};
            rv32i_types::op_imm: begin
                case (f3)
                    3'b111:  res = a & imm_i;
                    3'b110:  res = a | imm_i;
                    3'b100:  res = a ^ imm_i;
                    3'b010:  res = {31'd0, $signed(a) < $signed(imm_i)};
                    default: res = a + imm_i;
                endcase
            end
            rv32i_types::op_reg: begin
                case (f3)
                    3'b000:  res = inst[30] ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    3'b100:  res = a ^ b;
                    3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                    3'b001:  res = a << b[4:0];
                    default: res = a >> b[4:0];
                endcase
            end
            rv32i_types::op_br: begin
                wr = 1'b0;
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b) ||
                    (f3 == 3'b100 && $signed(a) < $signed(b))) begin
                    nxt = pc + imm_b;
                end
            end
            rv32i_types::op_load: begin
                addr = a + imm_i;
                res = img[addr[10:2]];
                c.ma = addr;
            end
            rv32i_types::op_store: begin
                wr = 1'b0;
                addr = a + imm_s;
                img[addr[10:2]] = b;
                c.ma = addr;
                c.mw = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            c.rd = inst[11:7];
            if (c.rd != 5'd0) begin
                xr[c.rd] = res;
                c.rdw = res;
            end
        end
        exp_q.push_back(c);
        halted = (inst == HALT);
        pc = nxt;
    end
endtask

`endif

// ==== tb/tb_mp4.sv ====
`include "cpu_params.svh"

module tb_mp4;

    localparam int NTESTS = 8;
    localparam int NINSTR = 24;
    localparam int LIMIT = 40 * NINSTR * NTESTS;
    localparam logic [31:0] HALT = 32'h0000_0063;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [31:0] rdw;
        logic [31:0] ma;
        logic [31:0] mw;
    } commit_t;

    logic clk, rst_n, bmem_read, bmem_write, bmem_resp, commit_valid;
    logic [31:0] bmem_address, commit_pc, commit_inst, commit_rd_wdata;
    logic [31:0] commit_mem_addr, commit_mem_wdata;
    logic [4:0] commit_rd_addr;
    logic [`CPU_BMEM_W-1:0] bmem_rdata, bmem_wdata, bm [256];
    logic [31:0] img [512];
    logic [31:0] rng;
    commit_t exp_q [$];
    commit_t e;
    int errors, test_errs, commits, cycles, cnt;
    logic test_active, seen_read, busy;

    `include "rv32i_ref_model.svh"

    mp4 i_mp4 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // random program at 0, data region 0x400..0x7fc
    task automatic build_program();
        logic [31:0] r;
        logic [4:0] rd, rs1, rs2;
        logic [11:0] off, st_off;
        logic [12:0] boff;
        logic [2:0] f3;
        st_off = 12'h400;
        for (int k = 0; k < 512; k++) begin
            img[k] = (k >= 256) ? rand32() : 32'd0;
        end
        for (int i = 0; i < NINSTR - 1; i++) begin
            r = rand32();
            rd = 5'(r[2:0]);
            rs1 = 5'(r[5:3]);
            rs2 = 5'(r[8:6]);
            off = 12'h400 + {r[16:9], 2'b00};
            case (rand32() % 6)
                0: img[i] = {r[31:12], rd, rv32i_types::op_lui};
                1: begin
                    case (r[19:17] % 5)
                        0: f3 = 3'b000;
                        1: f3 = 3'b111;
                        2: f3 = 3'b110;
                        3: f3 = 3'b100;
                        default: f3 = 3'b010;
                    endcase
                    img[i] = {r[31:20], rs1, f3, rd, rv32i_types::op_imm};
                end
                2: begin
                    // no SLTU in the subset
                    f3 = (r[19:17] == 3'b011) ? 3'b101 : r[19:17];
                    img[i] = {1'b0, r[31] & (f3 == 3'b000), 5'd0, rs2, rs1, f3, rd,
                              rv32i_types::op_reg};
                end
                3: begin
                    f3 = (r[18:17] == 2'd0) ? 3'b000 : (r[18:17] == 2'd1) ? 3'b001 : 3'b100;
                    boff = 13'(4 * (1 + rand32() % (NINSTR - 1 - i)));
                    img[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                              rv32i_types::op_br};
                end
                4: begin
                    // often reread the last stored word or its beat neighbour
                    if (r[17]) begin
                        off = st_off ^ {9'd0, r[18], 2'b00};
                    end
                    img[i] = {off, 5'd0, 3'b010, rd, rv32i_types::op_load};
                end
                default: begin
                    st_off = off;
                    img[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0],
                              rv32i_types::op_store};
                end
            endcase
        end
        img[NINSTR-1] = HALT;
        for (int w = 0; w < 256; w++) begin
            bm[w] = {img[2*w+1], img[2*w]};
        end
    endtask

    // backing memory with 1 to 4 cycles of latency
    always @(posedge clk) begin
        if (!rst_n) begin
            bmem_resp <= 1'b0;
            busy <= 1'b0;
        end else if (bmem_resp) begin
            bmem_resp <= 1'b0;
            busy <= 1'b0;
        end else if (!busy && (bmem_read || bmem_write)) begin
            busy <= 1'b1;
            cnt <= 1 + rand32() % 4;
        end else if (busy) begin
            if (cnt <= 1) begin
                bmem_resp <= 1'b1;
                if (bmem_read) begin
                    bmem_rdata <= bm[bmem_address[10:3]];
                end else begin
                    bm[bmem_address[10:3]] <= bmem_wdata;
                end
            end else begin
                cnt <= cnt - 1;
            end
        end
    end

    // commit checker and first-request check
    always @(posedge clk) begin
        if (test_active && !seen_read) begin
            if (bmem_write) begin
                $display("bmem_write seen before the first instruction fetch");
                test_errs++;
            end
            if (bmem_read) begin
                seen_read = 1'b1;
                if (bmem_address != `CPU_RESET_PC) begin
                    $display("MISMATCH bmem_address: got %h expected %h",
                             bmem_address, `CPU_RESET_PC);
                    test_errs++;
                end
            end
        end
        if (test_active && commit_valid) begin
            commits++;
            if (exp_q.size() == 0) begin
                $display("commit at pc %h with no instruction left to retire", commit_pc);
                test_errs++;
                test_active = 1'b0;
            end else begin
                e = exp_q.pop_front();
                if (commit_pc != e.pc) begin
                    $display("MISMATCH commit_pc: got %h expected %h", commit_pc, e.pc);
                    test_errs++;
                end
                if (commit_inst != e.inst) begin
                    $display("MISMATCH commit_inst: got %h expected %h", commit_inst, e.inst);
                    test_errs++;
                end
                if (commit_rd_addr != e.rd) begin
                    $display("MISMATCH commit_rd_addr: got %h expected %h",
                             commit_rd_addr, e.rd);
                    test_errs++;
                end
                if (commit_rd_wdata != e.rdw) begin
                    $display("MISMATCH commit_rd_wdata: got %h expected %h",
                             commit_rd_wdata, e.rdw);
                    test_errs++;
                end
                if (commit_mem_addr != e.ma) begin
                    $display("MISMATCH commit_mem_addr: got %h expected %h",
                             commit_mem_addr, e.ma);
                    test_errs++;
                end
                if (commit_mem_wdata != e.mw) begin
                    $display("MISMATCH commit_mem_wdata: got %h expected %h",
                             commit_mem_wdata, e.mw);
                    test_errs++;
                end
                if (exp_q.size() == 0) begin
                    test_active = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: halt not committed within %0d cycles", LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        bmem_resp = 1'b0;
        bmem_rdata = '0;
        rng = 32'd78626;
        errors = 0;
        cycles = 0;
        test_active = 1'b0;
        for (int t = 0; t < NTESTS; t++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            @(posedge clk);
            build_program();
            run_model();
            repeat (3) @(posedge clk);
            test_errs = 0;
            commits = 0;
            if (commit_valid || bmem_read || bmem_write) begin
                $display("commit_valid or a bmem request is high during reset");
                test_errs++;
            end
            seen_read = 1'b0;
            test_active = 1'b1;
            rst_n <= 1'b1;
            while (test_active) begin
                @(posedge clk);
            end
            for (int k = 256; k < 512; k++) begin
                if (bm[k/2][(k%2)*32 +: 32] != img[k]) begin
                    $display("MISMATCH mem[%h]: got %h expected %h", k * 4,
                             bm[k/2][(k%2)*32 +: 32], img[k]);
                    test_errs++;
                end
            end
            $display("test %0d: %0d commits, %0d errors", t, commits, test_errs);
            errors += test_errs;
        end
        $display("%0d tests, %0d errors", NTESTS, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`include "cpu_params.svh"

module alu (
    input  rv32i_types::alu_op_t  op,
    input  logic [`CPU_XLEN-1:0]  a,
    input  logic [`CPU_XLEN-1:0]  b,
    output logic [`CPU_XLEN-1:0]  result,
    input  logic [2:0]            br_kind,
    output logic                  br_en
);

    always_comb begin
        case (op)
            rv32i_types::alu_add:   result = a + b;
            rv32i_types::alu_sub:   result = a - b;
            rv32i_types::alu_and:   result = a & b;
            rv32i_types::alu_or:    result = a | b;
            rv32i_types::alu_xor:   result = a ^ b;
            rv32i_types::alu_slt:   result = {31'd0, $signed(a) < $signed(b)};
            rv32i_types::alu_sll:   result = a << b[4:0];
            rv32i_types::alu_srl:   result = a >> b[4:0];
            rv32i_types::alu_passb: result = b;
            default:                result = '0;
        endcase
    end

    // br_kind is funct3 of the branch
    always_comb begin
        case (br_kind)
            3'b000:  br_en = (a == b);
            3'b001:  br_en = (a != b);
            3'b100:  br_en = $signed(a) < $signed(b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

// ==== verilog/bmem_arbiter.sv ====
`include "cpu_params.svh"

module bmem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   imem_read,
    input  logic [31:0]            imem_address,
    output logic [31:0]            imem_rdata,
    output logic                   imem_resp,
    input  logic                   dmem_read,
    input  logic                   dmem_write,
    input  logic [31:0]            dmem_address,
    input  logic [31:0]            dmem_wdata,
    output logic [31:0]            dmem_rdata,
    output logic                   dmem_resp,
    output logic [31:0]            bmem_address,
    output logic                   bmem_read,
    output logic                   bmem_write,
    input  logic [`CPU_BMEM_W-1:0] bmem_rdata,
    output logic [`CPU_BMEM_W-1:0] bmem_wdata,
    input  logic                   bmem_resp
);

    typedef enum logic [1:0] {st_idle, st_read, st_write} arb_state_t;

    arb_state_t state;
    logic serve_d, is_store;
    logic [31:0] req_addr, lane;
    logic [`CPU_BMEM_W-1:0] merge_buf;

    // requests stay up until their resp, so the live address is safe to use
    assign req_addr     = serve_d ? dmem_address : imem_address;
    assign bmem_address = {req_addr[31:3], 3'b000};
    assign bmem_read    = (state == st_read);
    assign bmem_write   = (state == st_write);
    assign bmem_wdata   = merge_buf;

    // address bit 2 picks the half
    assign lane       = req_addr[2] ? bmem_rdata[63:32] : bmem_rdata[31:0];
    assign imem_rdata = lane;
    assign dmem_rdata = lane;
    assign imem_resp  = bmem_read & bmem_resp & ~serve_d;
    assign dmem_resp  = serve_d & bmem_resp & ((bmem_read & ~is_store) | bmem_write);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            serve_d  <= 1'b0;
            is_store <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // data side goes first
                    if (dmem_read | dmem_write) begin
                        serve_d  <= 1'b1;
                        is_store <= dmem_write;
                        state    <= st_read;
                    end else if (imem_read) begin
                        serve_d  <= 1'b0;
                        is_store <= 1'b0;
                        state    <= st_read;
                    end
                end
                st_read: begin
                    if (bmem_resp) begin
                        state <= is_store ? st_write : st_idle;
                    end
                end
                st_write: begin
                    if (bmem_resp) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // store word dropped into the fetched beat
    always_ff @(posedge clk) begin
        if (bmem_read && bmem_resp) begin
            merge_buf <= req_addr[2] ? {dmem_wdata, bmem_rdata[31:0]}
                                     : {bmem_rdata[63:32], dmem_wdata};
        end
    end

endmodule

// ==== verilog/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// data and address width
`define CPU_XLEN 32

// one backing memory beat
`define CPU_BMEM_W 64

`define CPU_NREGS 32

`endif

// ==== verilog/mp4.sv ====
`include "cpu_params.svh"

module mp4 (
    input  logic                   clk,
    input  logic                   rst_n,

    output logic [31:0]            bmem_address,
    output logic                   bmem_read,
    output logic                   bmem_write,
    input  logic [`CPU_BMEM_W-1:0] bmem_rdata,
    output logic [`CPU_BMEM_W-1:0] bmem_wdata,
    input  logic                   bmem_resp,

    // one record per retired instruction
    output logic                   commit_valid,
    output logic [31:0]            commit_pc,
    output logic [31:0]            commit_inst,
    output logic [4:0]             commit_rd_addr,
    output logic [31:0]            commit_rd_wdata,
    output logic [31:0]            commit_mem_addr,
    output logic [31:0]            commit_mem_wdata
);

    logic if_valid, de_valid, exe_valid, mem_valid, wb_valid;
    logic [4:0] de_rs1, de_rs2, exe_rd, mem_rd, wb_rd;
    logic exe_we, mem_we, wb_we;
    logic exe_is_branch, br_en, mem_is_mem;
    logic if_de_ld, de_exe_ld, exe_mem_ld, mem_wb_ld;
    logic if_de_rst, de_exe_rst, load_pc;
    rv32i_types::pcmux_sel_t pcmux_sel;

    // split instruction and data memory ports
    logic imem_read, imem_resp;
    logic [31:0] imem_address, imem_rdata;
    logic dmem_read, dmem_write, dmem_resp;
    logic [31:0] dmem_address, dmem_wdata, dmem_rdata;

    mp4control control (.*);

    mp4datapath datapath (.*);

    bmem_arbiter arbiter (.*);

endmodule

// ==== verilog/mp4control.sv ====
module mp4control (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       if_valid, de_valid, exe_valid, mem_valid, wb_valid,
    input  logic [4:0] de_rs1, de_rs2, exe_rd, mem_rd, wb_rd,
    input  logic       exe_we, mem_we, wb_we,
    input  logic       exe_is_branch,
    input  logic       br_en,
    input  logic       mem_is_mem,
    input  logic       imem_resp,
    input  logic       dmem_resp,
    output logic       if_de_ld, de_exe_ld, exe_mem_ld, mem_wb_ld,
    output logic       if_de_rst, de_exe_rst,
    output logic       load_pc,
    output rv32i_types::pcmux_sel_t pcmux_sel
);

    logic if_done, mem_done;
    logic if_ok, mem_ok, advance;
    logic stall, br_taken;

    // older instruction still owes a register that decode reads
    function automatic logic raw_hit(input logic v, input logic we, input logic [4:0] rd);
        raw_hit = v && we && rd != 5'd0 && (rd == de_rs1 || rd == de_rs2);
    endfunction

    assign if_ok   = if_valid & (imem_resp | if_done);
    assign mem_ok  = ~(mem_valid & mem_is_mem) | dmem_resp | mem_done;
    assign advance = if_ok & mem_ok;

    assign stall = de_valid & (raw_hit(exe_valid, exe_we, exe_rd) |
                               raw_hit(mem_valid, mem_we, mem_rd) |
                               raw_hit(wb_valid, wb_we, wb_rd));
    assign br_taken = exe_valid & exe_is_branch & br_en;

    // a taken branch wins over the stall since decode is flushed anyway
    assign load_pc    = advance & (br_taken | ~stall);
    assign if_de_ld   = load_pc;
    assign if_de_rst  = advance & br_taken;
    assign de_exe_ld  = advance;
    assign de_exe_rst = advance & (br_taken | stall);
    assign exe_mem_ld = advance;
    assign mem_wb_ld  = advance;
    assign pcmux_sel  = br_taken ? rv32i_types::pc_br : rv32i_types::pc_seq;

    // responses that came in while the other side was still waiting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_done  <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            if_done  <= (if_done | imem_resp) & ~load_pc;
            mem_done <= (mem_done | dmem_resp) & ~advance;
        end
    end

endmodule

// ==== verilog/mp4datapath.sv ====
`include "cpu_params.svh"

module mp4datapath (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        if_de_ld, de_exe_ld, exe_mem_ld, mem_wb_ld,
    input  logic        if_de_rst, de_exe_rst,
    input  logic        load_pc,
    input  rv32i_types::pcmux_sel_t pcmux_sel,
    output logic        if_valid, de_valid, exe_valid, mem_valid, wb_valid,
    output logic [4:0]  de_rs1, de_rs2, exe_rd, mem_rd, wb_rd,
    output logic        exe_we, mem_we, wb_we,
    output logic        exe_is_branch,
    output logic        br_en,
    output logic        mem_is_mem,
    output logic        imem_read,
    output logic [31:0] imem_address,
    input  logic [31:0] imem_rdata,
    input  logic        imem_resp,
    output logic        dmem_read, dmem_write,
    output logic [31:0] dmem_address,
    output logic [31:0] dmem_wdata,
    input  logic [31:0] dmem_rdata,
    input  logic        dmem_resp,
    output logic        commit_valid,
    output logic [31:0] commit_pc, commit_inst,
    output logic [4:0]  commit_rd_addr,
    output logic [31:0] commit_rd_wdata, commit_mem_addr, commit_mem_wdata
);

    logic [`CPU_XLEN-1:0] pc, de_pc, if_inst_buf, fetch_inst, de_inst;
    logic if_held, mem_held;
    rv32i_types::control_word de_cw, exe_cw, mem_cw, wb_cw;
    rv32i_types::alu_op_t f3_op;
    logic [`CPU_XLEN-1:0] rs1_rdata, rs2_rdata, exe_rs1, exe_rs2, alu_b, exe_result;
    logic [`CPU_XLEN-1:0] exe_target, mem_alu, mem_rs2, mem_rdata_buf, mem_result;
    logic [`CPU_XLEN-1:0] wb_data, wb_addr, wb_wdata;
    logic [2:0] f3;

    // fetch
    assign imem_read    = if_valid & ~if_held;
    assign imem_address = pc;
    assign fetch_inst   = if_held ? if_inst_buf : imem_rdata;

    // decode
    assign f3 = de_inst[14:12];

    always_comb begin
        case (f3)
            3'b111:  f3_op = rv32i_types::alu_and;
            3'b110:  f3_op = rv32i_types::alu_or;
            3'b100:  f3_op = rv32i_types::alu_xor;
            3'b010:  f3_op = rv32i_types::alu_slt;
            3'b001:  f3_op = rv32i_types::alu_sll;
            3'b101:  f3_op = rv32i_types::alu_srl;
            default: f3_op = rv32i_types::alu_add;
        endcase
    end

    always_comb begin
        de_cw        = '0;
        de_cw.pc     = de_pc;
        de_cw.inst   = de_inst;
        de_cw.rs1    = de_inst[19:15];
        de_cw.rs2    = de_inst[24:20];
        de_cw.rd     = de_inst[11:7];
        de_cw.alu_op = rv32i_types::alu_add;
        de_cw.imm    = {{20{de_inst[31]}}, de_inst[31:20]};
        case (rv32i_types::rv32i_opcode'(de_inst[6:0]))
            rv32i_types::op_lui: begin
                de_cw.imm       = {de_inst[31:12], 12'd0};
                de_cw.alu_op    = rv32i_types::alu_passb;
                de_cw.b_imm     = 1'b1;
                de_cw.reg_write = 1'b1;
                de_cw.rs1       = 5'd0;
                de_cw.rs2       = 5'd0;
            end
            rv32i_types::op_imm: begin
                de_cw.alu_op    = f3_op;
                de_cw.b_imm     = 1'b1;
                de_cw.reg_write = 1'b1;
                de_cw.rs2       = 5'd0;
            end
            rv32i_types::op_reg: begin
                de_cw.alu_op    = (f3 == 3'b000 && de_inst[30]) ? rv32i_types::alu_sub : f3_op;
                de_cw.reg_write = 1'b1;
            end
            rv32i_types::op_br: begin
                de_cw.imm       = {{19{de_inst[31]}}, de_inst[31], de_inst[7],
                                   de_inst[30:25], de_inst[11:8], 1'b0};
                de_cw.is_branch = 1'b1;
                de_cw.br_kind   = f3;
                de_cw.rd        = 5'd0;
            end
            rv32i_types::op_load: begin
                de_cw.b_imm     = 1'b1;
                de_cw.mem_read  = 1'b1;
                de_cw.reg_write = 1'b1;
                de_cw.rs2       = 5'd0;
            end
            rv32i_types::op_store: begin
                de_cw.imm       = {{20{de_inst[31]}}, de_inst[31:25], de_inst[11:7]};
                de_cw.b_imm     = 1'b1;
                de_cw.mem_write = 1'b1;
                de_cw.rd        = 5'd0;
            end
            // unknown opcode retires as a no-op
            default: begin
                de_cw.rs1 = 5'd0;
                de_cw.rs2 = 5'd0;
                de_cw.rd  = 5'd0;
            end
        endcase
    end

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (commit_valid & wb_cw.reg_write),
        .rd_addr   (wb_cw.rd),
        .rd_wdata  (wb_data),
        .rs1_addr  (de_cw.rs1),
        .rs2_addr  (de_cw.rs2),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    // execute
    assign alu_b      = exe_cw.b_imm ? exe_cw.imm : exe_rs2;
    assign exe_target = exe_cw.pc + exe_cw.imm;

    alu u_alu (
        .op      (exe_cw.alu_op),
        .a       (exe_rs1),
        .b       (alu_b),
        .result  (exe_result),
        .br_kind (exe_cw.br_kind),
        .br_en   (br_en)
    );

    // memory
    assign dmem_read    = mem_valid & mem_cw.mem_read & ~mem_held;
    assign dmem_write   = mem_valid & mem_cw.mem_write & ~mem_held;
    assign dmem_address = mem_alu;
    assign dmem_wdata   = mem_rs2;
    assign mem_result   = ~mem_cw.mem_read ? mem_alu : (mem_held ? mem_rdata_buf : dmem_rdata);

    // hazard fields for control
    assign de_rs1        = de_cw.rs1;
    assign de_rs2        = de_cw.rs2;
    assign exe_rd        = exe_cw.rd;
    assign mem_rd        = mem_cw.rd;
    assign wb_rd         = wb_cw.rd;
    assign exe_we        = exe_cw.reg_write;
    assign mem_we        = mem_cw.reg_write;
    assign wb_we         = wb_cw.reg_write;
    assign exe_is_branch = exe_cw.is_branch;
    assign mem_is_mem    = mem_cw.mem_read | mem_cw.mem_write;

    // writeback and commit record
    assign commit_valid     = wb_valid & mem_wb_ld;
    assign commit_pc        = wb_cw.pc;
    assign commit_inst      = wb_cw.inst;
    assign commit_rd_addr   = wb_cw.rd;
    assign commit_rd_wdata  = (wb_cw.rd != 5'd0) ? wb_data : '0;
    assign commit_mem_addr  = (wb_cw.mem_read | wb_cw.mem_write) ? wb_addr : '0;
    assign commit_mem_wdata = wb_cw.mem_write ? wb_wdata : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `CPU_RESET_PC;
            if_valid  <= 1'b0;
            de_valid  <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            if_held   <= 1'b0;
            mem_held  <= 1'b0;
        end else begin
            if_valid <= 1'b1;
            if (load_pc) begin
                pc <= (pcmux_sel == rv32i_types::pc_br) ? exe_target : pc + 32'd4;
            end
            if_held  <= (if_held | imem_resp) & ~load_pc;
            mem_held <= (mem_held | dmem_resp) & ~exe_mem_ld;
            if (if_de_rst) begin
                de_valid <= 1'b0;
            end else if (if_de_ld) begin
                de_valid <= if_valid;
            end
            if (de_exe_rst) begin
                exe_valid <= 1'b0;
            end else if (de_exe_ld) begin
                exe_valid <= de_valid;
            end
            if (exe_mem_ld) begin
                mem_valid <= exe_valid;
            end
            if (mem_wb_ld) begin
                wb_valid <= mem_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_resp) begin
            if_inst_buf <= imem_rdata;
        end
        if (dmem_resp) begin
            mem_rdata_buf <= dmem_rdata;
        end
        if (if_de_ld) begin
            de_pc   <= pc;
            de_inst <= fetch_inst;
        end
        if (de_exe_ld) begin
            exe_cw  <= de_cw;
            exe_rs1 <= rs1_rdata;
            exe_rs2 <= rs2_rdata;
        end
        if (exe_mem_ld) begin
            mem_cw  <= exe_cw;
            mem_alu <= exe_result;
            mem_rs2 <= exe_rs2;
        end
        if (mem_wb_ld) begin
            wb_cw    <= mem_cw;
            wb_data  <= mem_result;
            wb_addr  <= mem_alu;
            wb_wdata <= mem_rs2;
        end
    end

endmodule

// ==== verilog/regfile.sv ====
`include "cpu_params.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  logic [4:0]           rd_addr,
    input  logic [`CPU_XLEN-1:0] rd_wdata,
    input  logic [4:0]           rs1_addr,
    input  logic [4:0]           rs2_addr,
    output logic [`CPU_XLEN-1:0] rs1_rdata,
    output logic [`CPU_XLEN-1:0] rs2_rdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    // a same-cycle writeback shows through to decode
    assign rs1_rdata = (rs1_addr == 5'd0) ? '0 :
                       (we && rd_addr == rs1_addr) ? rd_wdata : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == 5'd0) ? '0 :
                       (we && rd_addr == rs2_addr) ? rd_wdata : regs[rs2_addr];

endmodule

// ==== verilog/rv32i_types.sv ====
`include "cpu_params.svh"

package rv32i_types;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_passb
    } alu_op_t;

    typedef enum logic {
        pc_seq,
        pc_br
    } pcmux_sel_t;

    // one decoded instruction as it moves down the pipe
    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [31:0]          inst;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] imm;
        alu_op_t              alu_op;
        logic                 b_imm;
        logic                 is_branch;
        logic [2:0]           br_kind;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
    } control_word;

endpackage
